// ==== testbench/prof_input.dat ====
# C en freeze core[7:0] l1[4:0] dma[9:0]  (hex, driven for one cycle)
# R idx expected hold  (decimal) | X requester cycles  (decimal, en low)
R 0 0 0
# Cycle and retire counts
C 1 0 80 00 000
C 1 0 80 00 000
C 1 0 00 00 000
C 0 0 80 00 000
R 0 3 0
R 1 2 0
R 9 1 0
# Stall priority, highest set cause wins
C 1 0 7f 00 000
C 1 0 3f 00 000
C 1 0 1c 00 000
C 1 0 0b 00 000
C 1 0 06 00 000
C 1 0 03 00 000
C 1 0 01 00 000
C 1 0 ff 00 000
R 0 11 0
R 1 3 0
R 2 1 0
R 5 1 0
R 8 1 0
# L1 miss episodes and miss cycles
C 1 0 80 18 000
C 1 0 80 08 000
C 1 0 80 08 000
C 1 0 80 05 000
C 1 0 80 07 000
C 1 0 80 00 000
R 10 1 0
R 11 1 0
R 12 3 0
R 13 1 0
R 14 1 0
R 15 2 0
# DMA reads ic then dfetch, in-order completions, then one devict write
C 1 0 80 00 300
C 1 0 80 00 301
C 1 0 80 00 000
C 1 0 80 00 0c0
C 1 0 80 00 0c0
C 1 0 80 00 032
C 1 0 80 00 002
C 1 0 80 00 00e
C 1 0 80 00 000
R 16 1 0
R 17 4 0
R 18 1 0
R 19 4 0
R 20 1 0
R 21 3 0
# Random status with counting off, then settle the miss history
X 1 12
C 0 0 00 00 000
R 0 26 0
R 1 18 0
R 9 1 0
R 12 3 0
# Data held during four enabled cycles
R 0 26 4
R 0 30 0
R 9 5 0
# Freeze clears the bank
C 1 1 80 00 000
R 0 0 0
R 1 0 0
R 9 0 0
R 12 0 0
R 15 0 0
R 17 0 0
R 21 0 0
C 1 0 80 00 000
R 0 1 0

// ==== files.f ====
design/prof_event_pkg.sv
design/prof_counter_pkg.sv
design/prof_dma_tracker.sv
design/prof_event_decode.sv
design/prof_counter.sv
design/prof_readout.sv
design/prof_top.sv
testbench/tb_prof_top.sv

// ==== Makefile ====
TOP := tb_prof_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o sim

run: build
	./obj_dir/sim 2>&1 | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

lint:
	verilator --lint-only -Wall --top-module prof_top \
		design/prof_event_pkg.sv \
		design/prof_counter_pkg.sv \
		design/prof_dma_tracker.sv \
		design/prof_event_decode.sv \
		design/prof_counter.sv \
		design/prof_readout.sv \
		design/prof_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_prof_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_prof_top;

  import prof_event_pkg::*;
  import prof_counter_pkg::*;

  localparam int    clk_period_lp   = 4;
  localparam int    reset_cycles_lp = 8;
  localparam int    seed_init_lp    = 32'h85773a92;
  localparam string stim_file_lp    = "testbench/prof_input.dat";

  logic         clk;
  logic         reset;
  logic         freeze;
  logic         en;
  core_status_s core;
  l1_status_s   l1;
  dma_bus_s     dma;
  rd_req_s      rd_req;
  rd_rsp_s      rd_rsp;

  string        lines[$];
  int           seed;
  int unsigned  cycle_cnt   = 0;
  int unsigned  cycle_limit = 0;

  prof_top i_dut (
    .clk_i    (clk),
    .reset_i  (reset),
    .freeze_i (freeze),
    .en_i     (en),
    .core_i   (core),
    .l1_i     (l1),
    .dma_i    (dma),
    .rd_req_i (rd_req),
    .rd_rsp_o (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_count(cnt_idx_t idx, count_t got, count_t expected);
    if (got !== expected) begin
      fail_run($sformatf("Fail %0t: counter %0d read %0d, expected %0d",
                         $time, idx, got, expected));
    end
  endtask

  task automatic compare_ack(logic got, logic expected);
    if (got !== expected) begin
      fail_run($sformatf("Fail %0t: readout ack is %b, expected %b", $time, got, expected));
    end
  endtask

  task automatic apply_cycle(logic en_v, logic frz_v, core_status_s core_v,
                             l1_status_s l1_v, dma_bus_s dma_v);
    @(negedge clk);
    en     = en_v;
    freeze = frz_v;
    core   = core_v;
    l1     = l1_v;
    dma    = dma_v;
  endtask

  // Full four-phase read, optionally holding req over enabled cycles
  task automatic read_counter(cnt_idx_t idx, count_t expected, int hold);
    @(negedge clk);
    compare_ack(rd_rsp.ack, 1'b0);
    en     = 1'b0;
    rd_req = '{req: 1'b1, idx: idx};
    @(negedge clk);
    compare_ack(rd_rsp.ack, 1'b1);
    compare_count(idx, rd_rsp.data, expected);
    if (hold > 0) begin
      en = 1'b1;
      repeat (hold) begin
        @(negedge clk);
        compare_ack(rd_rsp.ack, 1'b1);
        compare_count(idx, rd_rsp.data, expected);
      end
      en = 1'b0;
    end
    rd_req.req = 1'b0;
    @(negedge clk);
    compare_ack(rd_rsp.ack, 1'b0);
  endtask

  // Noise on the status inputs with counting disabled
  task automatic drive_idle_random(dma_sel_e sel, int cycles);
    int r;
    repeat (cycles) begin
      @(negedge clk);
      en     = 1'b0;
      freeze = 1'b0;
      r      = $random(seed);
      core   = r[7:0];
      r      = $random(seed);
      l1     = r[4:0];
      dma    = '0;
      dma.sel = sel;
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen(stim_file_lp, "r");
    if (fd == 0) begin
      fail_run($sformatf("Could not open stimulus file %s", stim_file_lp));
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(string line);
    int n;
    int v0;
    int v1;
    int v2;
    int v3;
    int v4;
    case (line[0])
      "C": begin
        n = $sscanf(line, "C %h %h %h %h %h", v0, v1, v2, v3, v4);
        if (n != 5) begin
          fail_run($sformatf("Malformed cycle line in stimulus file: %s", line));
        end else begin
          apply_cycle(v0[0], v1[0], core_status_s'(v2[7:0]), l1_status_s'(v3[4:0]),
                      dma_bus_s'(v4[9:0]));
        end
      end
      "R": begin
        n = $sscanf(line, "R %d %d %d", v0, v1, v2);
        if (n != 3) begin
          fail_run($sformatf("Malformed read line in stimulus file: %s", line));
        end else begin
          read_counter(cnt_idx_t'(v0[4:0]), count_t'(v1), v2);
        end
      end
      "X": begin
        n = $sscanf(line, "X %d %d", v0, v1);
        if (n != 2) begin
          fail_run($sformatf("Malformed idle line in stimulus file: %s", line));
        end else begin
          drive_idle_random(dma_sel_e'(v0[1:0]), v1);
        end
      end
      default: begin
        fail_run($sformatf("Unknown line kind in stimulus file: %s", line));
      end
    endcase
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    seed   = seed_init_lp;
    reset  = 1'b1;
    freeze = 1'b0;
    en     = 1'b0;
    core   = '0;
    l1     = '0;
    dma    = '0;
    rd_req = '0;
    load_stimulus();
    cycle_limit = 20 * lines.size() + reset_cycles_lp;
    repeat (reset_cycles_lp) @(negedge clk);
    reset = 1'b0;
    foreach (lines[i]) begin
      run_line(lines[i]);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/prof_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module prof_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         freeze_i,
  input  logic                         en_i,
  input  prof_event_pkg::core_status_s core_i,
  input  prof_event_pkg::l1_status_s   l1_i,
  input  prof_event_pkg::dma_bus_s     dma_i,
  input  prof_counter_pkg::rd_req_s    rd_req_i,
  output prof_counter_pkg::rd_rsp_s    rd_rsp_o
);

  import prof_event_pkg::*;
  import prof_counter_pkg::*;

  dma_activity_s                act;
  cnt_up_t                      up;
  count_t [num_counters_lp-1:0] counts;

  prof_dma_tracker i_dma_tracker (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .freeze_i (freeze_i),
    .dma_i    (dma_i),
    .act_o    (act)
  );

  prof_event_decode i_event_decode (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .en_i    (en_i),
    .core_i  (core_i),
    .l1_i    (l1_i),
    .act_i   (act),
    .up_o    (up)
  );

  // One counter per event index
  for (genvar k = 0; k < num_counters_lp; k++) begin : g_cnt
    prof_counter i_counter (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .freeze_i (freeze_i),
      .up_i     (up[k]),
      .count_o  (counts[k])
    );
  end

  prof_readout i_readout (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .counts_i (counts),
    .req_i    (rd_req_i),
    .rsp_o    (rd_rsp_o)
  );

endmodule

`default_nettype wire

// ==== design/prof_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

module prof_readout (
  input  logic                                                           clk_i,
  input  logic                                                           reset_i,
  input  prof_counter_pkg::count_t [prof_counter_pkg::num_counters_lp-1:0] counts_i,
  input  prof_counter_pkg::rd_req_s                                      req_i,
  output prof_counter_pkg::rd_rsp_s                                      rsp_o
);

  import prof_counter_pkg::*;

  rd_rsp_s rsp_r;

  // Four-phase handshake, data frozen while ack is high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_r <= '0;
    end else if (req_i.req && !rsp_r.ack) begin
      rsp_r.ack  <= 1'b1;
      rsp_r.data <= counts_i[req_i.idx];
    end else if (!req_i.req && rsp_r.ack) begin
      rsp_r.ack <= 1'b0;
    end
  end

  assign rsp_o = rsp_r;

  idx_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.req |=> (!req_i.req || $stable(req_i.idx)));

  idx_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.req |-> (int'(req_i.idx) < num_counters_lp));

endmodule

`default_nettype wire

// ==== design/prof_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module prof_counter (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     freeze_i,
  input  logic                     up_i,
  output prof_counter_pkg::count_t count_o
);

  import prof_counter_pkg::*;

  count_t count_r;
  logic   at_max;

  assign at_max = (count_r == '1);

  // Freeze wins over an increment in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i | freeze_i) begin
      count_r <= '0;
    end else if (up_i && !at_max) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign count_o = count_r;

  no_wrap_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (at_max && !freeze_i) |=> (count_r != '0));

endmodule

`default_nettype wire

// ==== design/prof_event_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module prof_event_decode (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          en_i,
  input  prof_event_pkg::core_status_s  core_i,
  input  prof_event_pkg::l1_status_s    l1_i,
  input  prof_event_pkg::dma_activity_s act_i,
  output prof_counter_pkg::cnt_up_t     up_o
);

  import prof_event_pkg::*;
  import prof_counter_pkg::*;

  stall_reason_e reason;
  logic          ic_miss_r;
  logic          mem_busy_r;

  // Previous-cycle miss state for episode edges
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ic_miss_r  <= 1'b0;
      mem_busy_r <= 1'b0;
    end else begin
      ic_miss_r  <= l1_i.icache_miss;
      mem_busy_r <= l1_i.mem_busy;
    end
  end

  // First set cause wins
  always_comb begin
    if (core_i.ic_miss) begin
      reason = e_st_ic_miss;
    end else if (core_i.br_ovr) begin
      reason = e_st_br_ovr;
    end else if (core_i.fe_cmd) begin
      reason = e_st_fe_cmd;
    end else if (core_i.mispredict) begin
      reason = e_st_mispredict;
    end else if (core_i.dc_miss) begin
      reason = e_st_dc_miss;
    end else if (core_i.struct_haz) begin
      reason = e_st_struct_haz;
    end else if (core_i.data_haz) begin
      reason = e_st_data_haz;
    end else begin
      reason = e_st_unknown;
    end
  end

  always_comb begin
    up_o = '0;
    if (en_i) begin
      up_o[idx_mcycle]   = 1'b1;
      up_o[idx_minstret] = core_i.instret;
      up_o[stall_base_lp + int'(reason)] = ~core_i.instret;

      up_o[idx_ic_req]      = l1_i.icache_yumi;
      up_o[idx_ic_miss_cnt] = l1_i.icache_miss & ~ic_miss_r;
      up_o[idx_ic_miss]     = l1_i.icache_miss;
      // A replayed access is the same request again
      up_o[idx_dc_req]      = l1_i.dcache_v & ~l1_i.dcache_replay;
      up_o[idx_dc_miss_cnt] = l1_i.mem_busy & ~mem_busy_r;
      up_o[idx_dc_miss]     = l1_i.mem_busy;

      up_o[idx_rdma_ic_cnt]     = act_i.rd_ic_start;
      up_o[idx_rdma_ic]         = act_i.rd_ic_busy;
      up_o[idx_rdma_dfetch_cnt] = act_i.rd_dfetch_start;
      up_o[idx_rdma_dfetch]     = act_i.rd_dfetch_busy;
      up_o[idx_wdma_devict_cnt] = act_i.wr_devict_start;
      up_o[idx_wdma_devict]     = act_i.wr_devict_busy;
    end
  end

endmodule

`default_nettype wire

// ==== design/prof_dma_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module prof_dma_tracker (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          freeze_i,
  input  prof_event_pkg::dma_bus_s      dma_i,
  output prof_event_pkg::dma_activity_s act_o
);

  import prof_event_pkg::*;

  typedef logic [$clog2(dma_outstanding_lp+1)-1:0] out_cnt_t;
  typedef logic [$clog2(dma_outstanding_lp)-1:0]   ptr_t;

  logic     ar_hs;
  logic     r_done;
  logic     aw_hs;
  logic     b_hs;
  logic     ic_start;
  logic     dfetch_start;
  logic     devict_start;
  logic     fifo_empty;
  logic     fifo_full;
  dma_sel_e head_sel;
  dma_sel_e sel_mem [dma_outstanding_lp];
  ptr_t     wr_ptr_r;
  ptr_t     rd_ptr_r;
  out_cnt_t fifo_cnt_r;
  out_cnt_t ic_cnt_r;
  out_cnt_t dfetch_cnt_r;
  out_cnt_t devict_cnt_r;

  function automatic out_cnt_t step(out_cnt_t cnt, logic inc, logic dec);
    return cnt + out_cnt_t'(inc) - out_cnt_t'(dec);
  endfunction

  assign ar_hs  = dma_i.arvalid & dma_i.arready;
  assign r_done = dma_i.rlast & dma_i.rready;
  assign aw_hs  = dma_i.awvalid & dma_i.awready;
  assign b_hs   = dma_i.bvalid & dma_i.bready;

  assign ic_start     = ar_hs & (dma_i.sel == e_dma_ic);
  assign dfetch_start = ar_hs & (dma_i.sel == e_dma_dfetch);
  assign devict_start = aw_hs & (dma_i.sel == e_dma_devict);

  // Read data returns in AR order, so the head names the finishing requester
  assign head_sel   = sel_mem[rd_ptr_r];
  assign fifo_empty = (fifo_cnt_r == '0);
  assign fifo_full  = (fifo_cnt_r == out_cnt_t'(dma_outstanding_lp));

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      sel_mem[wr_ptr_r] <= dma_i.sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i | freeze_i) begin
      wr_ptr_r     <= '0;
      rd_ptr_r     <= '0;
      fifo_cnt_r   <= '0;
      ic_cnt_r     <= '0;
      dfetch_cnt_r <= '0;
      devict_cnt_r <= '0;
    end else begin
      wr_ptr_r     <= wr_ptr_r + ptr_t'(ar_hs);
      rd_ptr_r     <= rd_ptr_r + ptr_t'(r_done);
      fifo_cnt_r   <= step(fifo_cnt_r, ar_hs, r_done);
      ic_cnt_r     <= step(ic_cnt_r, ic_start, r_done & (head_sel == e_dma_ic));
      dfetch_cnt_r <= step(dfetch_cnt_r, dfetch_start, r_done & (head_sel == e_dma_dfetch));
      devict_cnt_r <= step(devict_cnt_r, devict_start, b_hs & (devict_cnt_r != '0));
    end
  end

  assign act_o = '{
    rd_ic_start:     ic_start,
    rd_ic_busy:      (ic_cnt_r != '0) | ic_start,
    rd_dfetch_start: dfetch_start,
    rd_dfetch_busy:  (dfetch_cnt_r != '0) | dfetch_start,
    wr_devict_start: devict_start,
    wr_devict_busy:  (devict_cnt_r != '0) | devict_start
  };

  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (reset_i || freeze_i)
    r_done |-> !fifo_empty);

  no_push_full_a: assert property (@(posedge clk_i) disable iff (reset_i || freeze_i)
    ar_hs |-> !fifo_full);

endmodule

`default_nettype wire

// ==== design/prof_counter_pkg.sv ====
`default_nettype none

package prof_counter_pkg;

  localparam int num_counters_lp = 22;
  localparam int count_width_lp  = 32;

  typedef logic [count_width_lp-1:0]  count_t;
  typedef logic [4:0]                 cnt_idx_t;
  typedef logic [num_counters_lp-1:0] cnt_up_t;

  localparam int idx_mcycle   = 0;
  localparam int idx_minstret = 1;

  // Stall counter k lives at stall_base_lp + reason
  localparam int stall_base_lp = 2;

  localparam int idx_ic_req      = 10;
  localparam int idx_ic_miss_cnt = 11;
  localparam int idx_ic_miss     = 12;
  localparam int idx_dc_req      = 13;
  localparam int idx_dc_miss_cnt = 14;
  localparam int idx_dc_miss     = 15;

  localparam int idx_rdma_ic_cnt     = 16;
  localparam int idx_rdma_ic         = 17;
  localparam int idx_rdma_dfetch_cnt = 18;
  localparam int idx_rdma_dfetch     = 19;
  localparam int idx_wdma_devict_cnt = 20;
  localparam int idx_wdma_devict     = 21;

  typedef struct packed {
    logic     req;
    cnt_idx_t idx;
  } rd_req_s;

  typedef struct packed {
    logic   ack;
    count_t data;
  } rd_rsp_s;

endpackage

`default_nettype wire

// ==== design/prof_event_pkg.sv ====
`default_nettype none

package prof_event_pkg;

  // Listed in charge priority, highest first
  typedef enum logic [2:0] {
    e_st_ic_miss    = 3'd0,
    e_st_br_ovr     = 3'd1,
    e_st_fe_cmd     = 3'd2,
    e_st_mispredict = 3'd3,
    e_st_dc_miss    = 3'd4,
    e_st_struct_haz = 3'd5,
    e_st_data_haz   = 3'd6,
    e_st_unknown    = 3'd7
  } stall_reason_e;

  typedef enum logic [1:0] {
    e_dma_ic     = 2'd0,
    e_dma_dfetch = 2'd1,
    e_dma_devict = 2'd2
  } dma_sel_e;

  // Commit and stall causes from the core
  typedef struct packed {
    logic instret;
    logic ic_miss;
    logic br_ovr;
    logic fe_cmd;
    logic mispredict;
    logic dc_miss;
    logic struct_haz;
    logic data_haz;
  } core_status_s;

  typedef struct packed {
    logic icache_yumi;
    logic icache_miss;
    logic dcache_v;
    logic dcache_replay;
    logic mem_busy;
  } l1_status_s;

  // Handshake wires of the DMA master, sel names the requester
  typedef struct packed {
    logic     arvalid;
    logic     arready;
    logic     rlast;
    logic     rready;
    logic     awvalid;
    logic     awready;
    logic     bvalid;
    logic     bready;
    dma_sel_e sel;
  } dma_bus_s;

  typedef struct packed {
    logic rd_ic_start;
    logic rd_ic_busy;
    logic rd_dfetch_start;
    logic rd_dfetch_busy;
    logic wr_devict_start;
    logic wr_devict_busy;
  } dma_activity_s;

  localparam int dma_outstanding_lp = 4;

endpackage

`default_nettype wire
